// ==== design/backend_pkg.sv ====
package backend_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////
    localparam int DATA_W     = 32;
    localparam int NUM_REGS   = 8;
    localparam int REG_ADDR_W = 3;
    localparam int EIP_W      = 32;
    localparam int IMM_W      = 32;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [EIP_W-1:0]      eip_t;
    // {zf, sf, cf, of}
    typedef logic [3:0]            flags_t;

    //////////////////////////////////////////////////////////////////////
    // micro-op encodings
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SHL = 4'd5,
        ALU_SHR = 4'd6,
        ALU_MOV = 4'd7,
        ALU_LEA = 4'd8
    } aluk_e;

    typedef enum logic [1:0] {
        COND_EQ     = 2'd0,
        COND_NE     = 2'd1,
        COND_LT     = 2'd2,
        COND_ALWAYS = 2'd3
    } cond_e;

    //////////////////////////////////////////////////////////////////////
    // stage bundles
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        aluk_e              aluk;
        reg_addr_t          dest;
        reg_addr_t          src1;
        reg_addr_t          src2;
        logic               use_imm;
        logic [IMM_W-1:0]   imm;
        logic [1:0]         scale;
        logic               is_br;
        cond_e              cond;
        logic               pred_taken;
        eip_t               pred_target;
        eip_t               eip;
        logic [3:0]         inst_len;
    } uop_t;

    // addr holds the branch target for branches
    typedef struct packed {
        logic       valid;
        aluk_e      aluk;
        reg_addr_t  dest;
        logic       writes_reg;
        data_t      op_a;
        data_t      op_b;
        data_t      addr;
        logic       is_br;
        cond_e      cond;
        logic       pred_taken;
        eip_t       pred_target;
        eip_t       eip;
        logic [3:0] inst_len;
    } rrag_ex_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        data_t     data;
    } reg_write_t;

    typedef struct packed {
        logic valid;
        logic taken;
        logic correct;
        eip_t fip;
    } br_report_t;

    typedef struct packed {
        data_t  result;
        flags_t flags;
        logic   flags_ld;
    } alu_out_t;

    typedef struct packed {
        logic taken;
        logic correct;
        eip_t fip;
    } br_out_t;

endpackage

// ==== design/reg_file.sv ====
`timescale 1ns/100ps

module reg_file import backend_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  reg_addr_t  rd_addr_a,
    input  reg_addr_t  rd_addr_b,
    output data_t      rd_data_a,
    output data_t      rd_data_b,
    input  reg_write_t wr
);

    data_t regs [NUM_REGS];

    // combinational reads, old value on a same-cycle write
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid) begin
            regs[wr.dest] <= wr.data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // write port comes from the writeback latch
    a_wr_dest_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        wr.valid |-> !$isunknown(wr.dest)
    ) else $error("register write with unknown index");

endmodule

// ==== design/rrag_stage.sv ====
`timescale 1ns/100ps

module rrag_stage import backend_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       uop_valid,
    input  uop_t       uop,
    output logic       stall,
    output reg_addr_t  rd_addr_a,
    output reg_addr_t  rd_addr_b,
    input  data_t      rd_data_a,
    input  data_t      rd_data_b,
    input  reg_write_t wb_pending,
    output rrag_ex_t   rrag_ex
);

    logic     reads_src1;
    logic     reads_src2;
    logic     hit_src1;
    logic     hit_src2;
    data_t    lea_addr;
    rrag_ex_t ex_d;

    assign rd_addr_a = uop.src1;
    assign rd_addr_b = uop.src2;

    //////////////////////////////////////////////////////////////////////
    // hazard detection
    //////////////////////////////////////////////////////////////////////
    assign reads_src1 = (uop.aluk != ALU_MOV);
    assign reads_src2 = !uop.use_imm || (uop.aluk == ALU_LEA);

    // producer in execute or in writeback
    assign hit_src1 = (rrag_ex.valid && rrag_ex.writes_reg && rrag_ex.dest == uop.src1) ||
                      (wb_pending.valid && wb_pending.dest == uop.src1);
    assign hit_src2 = (rrag_ex.valid && rrag_ex.writes_reg && rrag_ex.dest == uop.src2) ||
                      (wb_pending.valid && wb_pending.dest == uop.src2);

    assign stall = uop_valid && ((reads_src1 && hit_src1) || (reads_src2 && hit_src2));

    //////////////////////////////////////////////////////////////////////
    // operands and address generation
    //////////////////////////////////////////////////////////////////////
    assign lea_addr = rd_data_a + (rd_data_b << uop.scale) + uop.imm;

    always_comb begin
        ex_d             = '0;
        ex_d.valid       = uop_valid && !stall;
        ex_d.aluk        = uop.aluk;
        ex_d.dest        = uop.dest;
        ex_d.writes_reg  = !uop.is_br;
        ex_d.op_a        = rd_data_a;
        ex_d.op_b        = (uop.use_imm || uop.aluk == ALU_MOV) ? uop.imm : rd_data_b;
        // branch target is eip relative
        ex_d.addr        = uop.is_br ? (uop.eip + uop.imm) : lea_addr;
        ex_d.is_br       = uop.is_br;
        ex_d.cond        = uop.cond;
        ex_d.pred_taken  = uop.pred_taken;
        ex_d.pred_target = uop.pred_target;
        ex_d.eip         = uop.eip;
        ex_d.inst_len    = uop.inst_len;
    end

    // stall or empty slot loads a bubble
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rrag_ex <= '0;
        end else if (ex_d.valid) begin
            rrag_ex <= ex_d;
        end else begin
            rrag_ex <= '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // source holds the micro-op while stalled
    a_hold_while_stall: assert property (
        @(posedge clk) disable iff (!arst_n)
        stall |=> uop_valid && $stable(uop)
    ) else $error("micro-op changed while stalled");

endmodule

// ==== design/alu_unit.sv ====
`timescale 1ns/100ps

module alu_unit import backend_pkg::*; (
    input  rrag_ex_t rrag_ex,
    input  flags_t   flags_in,
    output alu_out_t alu_out
);

    logic          sub;
    data_t         b_eff;
    logic [DATA_W:0] sum_w;
    data_t         sum;
    logic          add_cf;
    logic          add_of;
    data_t         logic_res;

    //////////////////////////////////////////////////////////////////////
    // shared adder for add and sub
    //////////////////////////////////////////////////////////////////////
    assign sub   = (rrag_ex.aluk == ALU_SUB);
    assign b_eff = sub ? ~rrag_ex.op_b : rrag_ex.op_b;
    assign sum_w = {1'b0, rrag_ex.op_a} + {1'b0, b_eff} + {{DATA_W{1'b0}}, sub};
    assign sum   = sum_w[DATA_W-1:0];

    // carry out inverted gives the borrow
    assign add_cf = sub ? ~sum_w[DATA_W] : sum_w[DATA_W];
    assign add_of = (rrag_ex.op_a[DATA_W-1] == b_eff[DATA_W-1]) &&
                    (sum[DATA_W-1] != rrag_ex.op_a[DATA_W-1]);

    always_comb begin
        case (rrag_ex.aluk)
            ALU_AND: logic_res = rrag_ex.op_a & rrag_ex.op_b;
            ALU_OR:  logic_res = rrag_ex.op_a | rrag_ex.op_b;
            default: logic_res = rrag_ex.op_a ^ rrag_ex.op_b;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // result and flags
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        alu_out.result   = '0;
        alu_out.flags    = flags_in;
        alu_out.flags_ld = 1'b0;
        case (rrag_ex.aluk)
            ALU_ADD, ALU_SUB: begin
                alu_out.result   = sum;
                alu_out.flags    = {sum == '0, sum[DATA_W-1], add_cf, add_of};
                alu_out.flags_ld = 1'b1;
            end
            ALU_AND, ALU_OR, ALU_XOR: begin
                alu_out.result   = logic_res;
                alu_out.flags    = {logic_res == '0, logic_res[DATA_W-1], 2'b00};
                alu_out.flags_ld = 1'b1;
            end
            ALU_SHL: alu_out.result = rrag_ex.op_a << rrag_ex.op_b[4:0];
            ALU_SHR: alu_out.result = rrag_ex.op_a >> rrag_ex.op_b[4:0];
            ALU_MOV: alu_out.result = rrag_ex.op_b;
            ALU_LEA: alu_out.result = rrag_ex.addr;
            default: alu_out.result = '0;
        endcase
        // branches keep the flags
        if (rrag_ex.is_br) begin
            alu_out.flags    = flags_in;
            alu_out.flags_ld = 1'b0;
        end
    end

endmodule

// ==== design/branch_unit.sv ====
`timescale 1ns/100ps

module branch_unit import backend_pkg::*; (
    input  rrag_ex_t rrag_ex,
    output br_out_t  br_out
);

    logic taken;
    eip_t target;
    eip_t fall_thru;

    // condition on the two operands
    always_comb begin
        case (rrag_ex.cond)
            COND_EQ: taken = (rrag_ex.op_a == rrag_ex.op_b);
            COND_NE: taken = (rrag_ex.op_a != rrag_ex.op_b);
            COND_LT: taken = ($signed(rrag_ex.op_a) < $signed(rrag_ex.op_b));
            default: taken = 1'b1;
        endcase
    end

    // eip + imm, formed in the address generator
    assign target    = rrag_ex.addr;
    assign fall_thru = rrag_ex.eip + {{(EIP_W-4){1'b0}}, rrag_ex.inst_len};

    //////////////////////////////////////////////////////////////////////
    // prediction check
    //////////////////////////////////////////////////////////////////////
    assign br_out.taken   = taken;
    assign br_out.fip     = taken ? target : fall_thru;
    assign br_out.correct = (taken == rrag_ex.pred_taken) &&
                            (!taken || target == rrag_ex.pred_target);

endmodule

// ==== design/wb_stage.sv ====
`timescale 1ns/100ps

module wb_stage import backend_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  rrag_ex_t   rrag_ex,
    input  alu_out_t   alu_out,
    input  br_out_t    br_out,
    output reg_write_t wb,
    output br_report_t br,
    output flags_t     flags
);

    //////////////////////////////////////////////////////////////////////
    // execute to writeback latch
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb <= '0;
            br <= '0;
        end else begin
            wb.valid   <= rrag_ex.valid && rrag_ex.writes_reg;
            wb.dest    <= rrag_ex.dest;
            wb.data    <= alu_out.result;
            br.valid   <= rrag_ex.valid && rrag_ex.is_br;
            br.taken   <= br_out.taken;
            br.correct <= br_out.correct;
            br.fip     <= br_out.fip;
        end
    end

    // flags register, loads with the latch
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else if (rrag_ex.valid && alu_out.flags_ld) begin
            flags <= alu_out.flags;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // one micro-op per slot, either a write or a branch report
    a_one_result: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(wb.valid && br.valid)
    ) else $error("register write and branch report in the same cycle");

endmodule

// ==== design/backend_top.sv ====
`timescale 1ns/100ps

module backend_top import backend_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       uop_valid,
    input  uop_t       uop,
    output logic       stall,
    output reg_write_t wb,
    output br_report_t br,
    output flags_t     flags
);

    reg_addr_t rd_addr_a;
    reg_addr_t rd_addr_b;
    data_t     rd_data_a;
    data_t     rd_data_b;
    rrag_ex_t  rrag_ex;
    alu_out_t  alu_out;
    br_out_t   br_out;

    reg_file i_reg_file (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr        (wb)
    );

    // register read, address generation, hazard stall
    rrag_stage i_rrag_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .uop_valid  (uop_valid),
        .uop        (uop),
        .stall      (stall),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .wb_pending (wb),
        .rrag_ex    (rrag_ex)
    );

    //////////////////////////////////////////////////////////////////////
    // execute
    //////////////////////////////////////////////////////////////////////
    alu_unit i_alu_unit (
        .rrag_ex  (rrag_ex),
        .flags_in (flags),
        .alu_out  (alu_out)
    );

    branch_unit i_branch_unit (
        .rrag_ex (rrag_ex),
        .br_out  (br_out)
    );

    wb_stage i_wb_stage (
        .clk     (clk),
        .arst_n  (arst_n),
        .rrag_ex (rrag_ex),
        .alu_out (alu_out),
        .br_out  (br_out),
        .wb      (wb),
        .br      (br),
        .flags   (flags)
    );

endmodule

// ==== testbench/backend_vectors.svh ====
`ifndef BACKEND_VECTORS_SVH
`define BACKEND_VECTORS_SVH

// one row: the micro-op and what it should produce
typedef struct packed {
    uop_t   uop;
    logic   is_br;
    data_t  data;
    logic   taken;
    logic   correct;
    eip_t   fip;
    flags_t flags;
} vec_t;

localparam int NUM_VECS = 20;

vec_t vecs [NUM_VECS];

function automatic uop_t alu_uop(aluk_e aluk, reg_addr_t dest, reg_addr_t src1,
                                 reg_addr_t src2, logic use_imm, data_t imm,
                                 logic [1:0] scale);
    uop_t u;
    u          = '0;
    u.aluk     = aluk;
    u.dest     = dest;
    u.src1     = src1;
    u.src2     = src2;
    u.use_imm  = use_imm;
    u.imm      = imm;
    u.scale    = scale;
    u.inst_len = 4'd3;
    return u;
endfunction

function automatic uop_t jump_uop(cond_e cond, reg_addr_t src1, reg_addr_t src2,
                                  eip_t eip, logic [3:0] len, data_t imm,
                                  logic pred_taken, eip_t pred_target);
    uop_t u;
    u             = '0;
    u.aluk        = ALU_ADD;
    u.src1        = src1;
    u.src2        = src2;
    u.imm         = imm;
    u.is_br       = 1'b1;
    u.cond        = cond;
    u.pred_taken  = pred_taken;
    u.pred_target = pred_target;
    u.eip         = eip;
    u.inst_len    = len;
    return u;
endfunction

function automatic vec_t reg_result(uop_t u, data_t data, flags_t flags);
    vec_t v;
    v       = '0;
    v.uop   = u;
    v.data  = data;
    v.flags = flags;
    return v;
endfunction

function automatic vec_t branch_result(uop_t u, logic taken, logic correct, eip_t fip,
                                       flags_t flags);
    vec_t v;
    v         = '0;
    v.uop     = u;
    v.is_br   = 1'b1;
    v.taken   = taken;
    v.correct = correct;
    v.fip     = fip;
    v.flags   = flags;
    return v;
endfunction

// flags column is {zf, sf, cf, of} after the micro-op
task automatic load_table();
    vecs[0]  = reg_result(alu_uop(ALU_ADD, 3'd1, 3'd2, 3'd3, 1'b0, 32'h0, 2'd0),
                          32'h0000_0000, 4'b1000);
    vecs[1]  = reg_result(alu_uop(ALU_MOV, 3'd1, 3'd0, 3'd0, 1'b1, 32'h5, 2'd0),
                          32'h0000_0005, 4'b1000);
    vecs[2]  = reg_result(alu_uop(ALU_MOV, 3'd2, 3'd0, 3'd0, 1'b1, 32'hFFFF_FFFF, 2'd0),
                          32'hFFFF_FFFF, 4'b1000);
    // depends on both movs, carry out
    vecs[3]  = reg_result(alu_uop(ALU_ADD, 3'd3, 3'd1, 3'd2, 1'b0, 32'h0, 2'd0),
                          32'h0000_0004, 4'b0010);
    vecs[4]  = reg_result(alu_uop(ALU_SUB, 3'd4, 3'd1, 3'd0, 1'b1, 32'h7, 2'd0),
                          32'hFFFF_FFFE, 4'b0110);
    vecs[5]  = reg_result(alu_uop(ALU_AND, 3'd5, 3'd2, 3'd0, 1'b1, 32'h0F0F_00F0, 2'd0),
                          32'h0F0F_00F0, 4'b0000);
    vecs[6]  = reg_result(alu_uop(ALU_OR, 3'd5, 3'd5, 3'd0, 1'b1, 32'h8000_0001, 2'd0),
                          32'h8F0F_00F1, 4'b0100);
    vecs[7]  = reg_result(alu_uop(ALU_XOR, 3'd6, 3'd5, 3'd5, 1'b0, 32'h0, 2'd0),
                          32'h0000_0000, 4'b1000);
    vecs[8]  = reg_result(alu_uop(ALU_SHL, 3'd6, 3'd1, 3'd0, 1'b1, 32'h4, 2'd0),
                          32'h0000_0050, 4'b1000);
    // only the low 5 bits of the amount count
    vecs[9]  = reg_result(alu_uop(ALU_SHR, 3'd7, 3'd2, 3'd0, 1'b1, 32'h24, 2'd0),
                          32'h0FFF_FFFF, 4'b1000);
    vecs[10] = reg_result(alu_uop(ALU_LEA, 3'd7, 3'd1, 3'd3, 1'b1, 32'h100, 2'd2),
                          32'h0000_0115, 4'b1000);
    vecs[11] = reg_result(alu_uop(ALU_ADD, 3'd6, 3'd5, 3'd5, 1'b0, 32'h0, 2'd0),
                          32'h1E1E_01E2, 4'b0011);
    // branches
    vecs[12] = branch_result(jump_uop(COND_EQ, 3'd1, 3'd1, 32'h1000, 4'd2, 32'h20,
                                      1'b1, 32'h1020), 1'b1, 1'b1, 32'h1020, 4'b0011);
    vecs[13] = branch_result(jump_uop(COND_NE, 3'd1, 3'd1, 32'h1040, 4'd3, 32'h10,
                                      1'b0, 32'h0), 1'b0, 1'b1, 32'h1043, 4'b0011);
    vecs[14] = branch_result(jump_uop(COND_LT, 3'd2, 3'd1, 32'h2000, 4'd2, 32'h80,
                                      1'b0, 32'h0), 1'b1, 1'b0, 32'h2080, 4'b0011);
    vecs[15] = branch_result(jump_uop(COND_ALWAYS, 3'd0, 3'd0, 32'h3000, 4'd5,
                                      32'hFFFF_FF00, 1'b1, 32'h3100),
                             1'b1, 1'b0, 32'h2F00, 4'b0011);
    vecs[16] = branch_result(jump_uop(COND_LT, 3'd1, 3'd2, 32'h4000, 4'd2, 32'h40,
                                      1'b0, 32'h0), 1'b0, 1'b1, 32'h4002, 4'b0011);
    // dependent chain at the end
    vecs[17] = reg_result(alu_uop(ALU_SUB, 3'd1, 3'd3, 3'd3, 1'b0, 32'h0, 2'd0),
                          32'h0000_0000, 4'b1000);
    vecs[18] = reg_result(alu_uop(ALU_ADD, 3'd2, 3'd1, 3'd0, 1'b1, 32'h3, 2'd0),
                          32'h0000_0003, 4'b0000);
    vecs[19] = reg_result(alu_uop(ALU_SUB, 3'd3, 3'd2, 3'd6, 1'b0, 32'h0, 2'd0),
                          32'hE1E1_FE21, 4'b0110);
endtask

`endif

// ==== testbench/tb_backend.sv ====
`timescale 1ns/100ps

module tb_backend
    import backend_pkg::*;
();

    logic       clk;
    logic       arst_n;
    logic       uop_valid;
    uop_t       uop;
    logic       stall;
    reg_write_t wb;
    br_report_t br;
    flags_t     flags;

    int errors       = 0;
    int results_seen = 0;
    int stall_cycles = 0;
    int pending [$];

    `include "backend_vectors.svh"

    backend_top i_backend_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .uop_valid (uop_valid),
        .uop       (uop),
        .stall     (stall),
        .wb        (wb),
        .br        (br),
        .flags     (flags)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // result checker
    //////////////////////////////////////////////////////////////////////
    task automatic check_result(int idx);
        vec_t v;
        v = vecs[idx];
        if (v.is_br) begin
            if (!br.valid || wb.valid) begin
                $display("entry %0d wrote a register instead of reporting a branch", idx);
                errors++;
            end
            if (br.taken !== v.taken) begin
                $display("MISMATCH entry %0d br.taken: got %h expected %h", idx, br.taken,
                         v.taken);
                errors++;
            end
            if (br.correct !== v.correct) begin
                $display("MISMATCH entry %0d br.correct: got %h expected %h", idx,
                         br.correct, v.correct);
                errors++;
            end
            if (br.fip !== v.fip) begin
                $display("MISMATCH entry %0d br.fip: got %h expected %h", idx, br.fip, v.fip);
                errors++;
            end
        end else begin
            if (!wb.valid || br.valid) begin
                $display("entry %0d reported a branch instead of writing a register", idx);
                errors++;
            end
            if (wb.dest !== v.uop.dest) begin
                $display("MISMATCH entry %0d wb.dest: got %h expected %h", idx, wb.dest,
                         v.uop.dest);
                errors++;
            end
            if (wb.data !== v.data) begin
                $display("MISMATCH entry %0d wb.data: got %h expected %h", idx, wb.data,
                         v.data);
                errors++;
            end
        end
        if (flags !== v.flags) begin
            $display("MISMATCH entry %0d flags: got %h expected %h", idx, flags, v.flags);
            errors++;
        end
    endtask

    // results leave in program order
    initial begin
        int idx;
        forever begin
            @(negedge clk);
            if (arst_n && (wb.valid || br.valid)) begin
                if (pending.size() == 0) begin
                    $display("result appeared with no micro-op outstanding");
                    errors++;
                end else begin
                    idx = pending.pop_front();
                    check_result(idx);
                    results_seen++;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic accepted;
        arst_n    = 1'b0;
        uop_valid = 1'b0;
        uop       = '0;
        load_table();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        if (stall || wb.valid || br.valid || flags !== 4'b0000) begin
            $display("outputs not idle after reset");
            errors++;
        end
        @(posedge clk);
        for (int i = 0; i < NUM_VECS; i++) begin
            uop_valid <= 1'b1;
            uop       <= vecs[i].uop;
            accepted = 1'b0;
            // hold the micro-op while stalled
            while (!accepted) begin
                @(negedge clk);
                if (stall) begin
                    stall_cycles++;
                end else begin
                    pending.push_back(i);
                    accepted = 1'b1;
                end
                @(posedge clk);
            end
        end
        uop_valid <= 1'b0;
        uop       <= '0;
        wait (results_seen == NUM_VECS);
        repeat (3) @(negedge clk);
        if (stall_cycles == 0) begin
            $display("stall was never raised by a dependent micro-op");
            errors++;
        end
        $display("errors: %0d, results checked: %0d of %0d, stall cycles: %0d", errors,
                 results_seen, NUM_VECS, stall_cycles);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (NUM_VECS * 4 + 20) @(posedge clk);
        $display("timeout with %0d of %0d results seen", results_seen, NUM_VECS);
        $display("errors: %0d, results checked: %0d of %0d, stall cycles: %0d", errors + 1,
                 results_seen, NUM_VECS, stall_cycles);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+testbench
design/backend_pkg.sv
design/reg_file.sv
design/rrag_stage.sv
design/alu_unit.sv
design/branch_unit.sv
design/wb_stage.sv
design/backend_top.sv
testbench/tb_backend.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f flist.f --top-module tb_backend -o sim_backend

output=$(./obj_dir/sim_backend)
echo "$output"

if grep -qx "Test OK" <<< "$output"; then
    exit 0
fi
exit 1
